/* design/game_pkg.sv */
package game_pkg;

    // zero in either field marks an empty slot
    typedef struct packed {
        logic [1:0] color;   // 1..3
        logic [2:0] number;  // 1..5
    } card_t;

    typedef enum logic {
        PLAYER1 = 1'b0,
        PLAYER2 = 1'b1
    } player_e;

    // keypad opcodes, anything else is ignored
    typedef enum logic [3:0] {
        KEY_NONE    = 4'b0000,
        KEY_FLIP_P1 = 4'b0011,
        KEY_FLIP_P2 = 4'b0001,
        KEY_RING_P1 = 4'b1100,
        KEY_RING_P2 = 4'b1000
    } key_code_e;

    typedef enum logic {
        TURN_P1 = 1'b0,
        TURN_P2 = 1'b1
    } turn_state_e;

    typedef logic [7:0] score_t;

endpackage

/* design/bus_pkg.sv */
package bus_pkg;

    localparam int WB_ADR_W = 3;
    localparam int WB_DAT_W = 8;

    // host register map
    typedef enum logic [WB_ADR_W-1:0] {
        REG_STATUS   = 3'd0,  // {winner, game_over, turn}
        REG_CARD_P1  = 3'd1,
        REG_CARD_P2  = 3'd2,
        REG_SCORE_P1 = 3'd3,
        REG_SCORE_P2 = 3'd4,
        REG_CONTROL  = 3'd5   // bit 0 starts a new game
    } reg_addr_e;

endpackage

/* design/card_if.sv */
`timescale 1ns/1ps

// one dealt card, valid for a single cycle
interface card_if
    import game_pkg::*;
();

    logic       valid;
    player_e    player;   // slot that receives the card
    logic [1:0] color;
    logic [2:0] number;

    modport dealer (
        output valid,
        output player,
        output color,
        output number
    );

    // receiving side, named tbl since table is a reserved word
    modport tbl (
        input valid,
        input player,
        input color,
        input number
    );

endinterface

/* design/turn_control.sv */
`timescale 1ns/1ps

module turn_control
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  keypad,
    input  logic        game_over,
    input  logic        new_game,
    output logic        deal,
    output player_e     deal_player,
    output logic        ring,
    output player_e     ring_player,
    output turn_state_e turn
);

    key_code_e key;

    assign key = key_code_e'(keypad);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            turn        <= TURN_P1;
            deal        <= 1'b0;
            deal_player <= PLAYER1;
            ring        <= 1'b0;
            ring_player <= PLAYER1;
        end else begin
            deal <= 1'b0;  // both are single-cycle pulses
            ring <= 1'b0;
            if (new_game) begin
                turn <= TURN_P1;
            end else if (!game_over) begin
                case (key)
                    KEY_FLIP_P1: begin
                        if (turn == TURN_P1) begin
                            deal        <= 1'b1;
                            deal_player <= PLAYER1;
                            turn        <= TURN_P2;
                        end
                    end
                    KEY_FLIP_P2: begin
                        if (turn == TURN_P2) begin
                            deal        <= 1'b1;
                            deal_player <= PLAYER2;
                            turn        <= TURN_P1;
                        end
                    end
                    // the bell is open to both players at any time
                    KEY_RING_P1: begin
                        ring        <= 1'b1;
                        ring_player <= PLAYER1;
                    end
                    KEY_RING_P2: begin
                        ring        <= 1'b1;
                        ring_player <= PLAYER2;
                    end
                    default: ;  // KEY_NONE and unknown codes
                endcase
            end
        end
    end

endmodule

/* design/card_dealer.sv */
`timescale 1ns/1ps

module card_dealer
    import game_pkg::*;
#(
    parameter logic [4:0] LFSR_SEED = 5'b11100
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    deal,
    input  player_e deal_player,
    card_if.dealer  cards
);

    logic [4:0] lfsr_q;
    logic [4:0] lfsr_nxt;
    logic [1:0] map_color;
    logic [2:0] map_number;

    // shift left, taps 4 and 2 feed bit 0
    always_comb begin
        lfsr_nxt    = lfsr_q << 1;
        lfsr_nxt[0] = lfsr_q[2] ^ lfsr_q[4];
    end

    // card comes from the value before the step
    assign map_color  = (lfsr_q[4:3] % 2'd3) + 2'd1;
    assign map_number = (lfsr_q[2:0] % 3'd5) + 3'd1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lfsr_q      <= LFSR_SEED;
            cards.valid <= 1'b0;
        end else begin
            cards.valid <= deal;
            if (deal) begin
                lfsr_q <= lfsr_nxt;  // only steps on a deal
            end
        end
    end

    // card fields only matter while valid is high
    always_ff @(posedge clk) begin
        if (deal) begin
            cards.player <= deal_player;
            cards.color  <= map_color;
            cards.number <= map_number;
        end
    end

endmodule

/* design/card_table.sv */
`timescale 1ns/1ps

module card_table
    import game_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    card_if.tbl   cards,
    input  logic  collect,
    input  logic  new_game,
    output card_t card_p1,
    output card_t card_p2,
    output logic  match
);

    logic [3:0] color_sum [1:3];  // face-up total per colour
    card_t      dealt;

    assign dealt = '{color: cards.color, number: cards.number};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            card_p1 <= '0;
            card_p2 <= '0;
        end else if (collect || new_game) begin
            card_p1 <= '0;  // both slots emptied
            card_p2 <= '0;
        end else if (cards.valid) begin
            if (cards.player == PLAYER1) begin
                card_p1 <= dealt;
            end else begin
                card_p2 <= dealt;
            end
        end
    end

    // empty slots have colour 0 and never count
    always_comb begin
        for (int c = 1; c <= 3; c++) begin
            color_sum[c] =
                {1'b0, (card_p1.color == 2'(c)) ? card_p1.number : 3'd0} +
                {1'b0, (card_p2.color == 2'(c)) ? card_p2.number : 3'd0};
        end
    end

    assign match = (color_sum[1] == 4'd5) ||
                   (color_sum[2] == 4'd5) ||
                   (color_sum[3] == 4'd5);

endmodule

/* design/bell_judge.sv */
`timescale 1ns/1ps

module bell_judge
    import game_pkg::*;
#(
    parameter int unsigned WIN_SCORE = 5
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    ring,
    input  player_e ring_player,
    input  logic    match,
    input  logic    new_game,
    output score_t  score_p1,
    output score_t  score_p2,
    output logic    collect,
    output logic    game_over,
    output player_e winner
);

    player_e credited;
    score_t  score_p1_nxt;
    score_t  score_p2_nxt;

    // right ring pays the ringer, wrong ring pays the opponent
    assign credited = match ? ring_player : player_e'(~ring_player);

    assign score_p1_nxt = score_p1 + score_t'(ring && credited == PLAYER1);
    assign score_p2_nxt = score_p2 + score_t'(ring && credited == PLAYER2);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            score_p1  <= '0;
            score_p2  <= '0;
            collect   <= 1'b0;
            game_over <= 1'b0;
            winner    <= PLAYER1;
        end else begin
            collect <= 1'b0;
            if (new_game) begin
                score_p1  <= '0;
                score_p2  <= '0;
                game_over <= 1'b0;
                winner    <= PLAYER1;
            end else if (ring) begin
                score_p1 <= score_p1_nxt;
                score_p2 <= score_p2_nxt;
                collect  <= match;  // table clears next edge
                if (score_p1_nxt >= score_t'(WIN_SCORE) ||
                    score_p2_nxt >= score_t'(WIN_SCORE)) begin
                    game_over <= 1'b1;
                    winner    <= credited;
                end
            end
        end
    end

endmodule

/* design/wb_status_regs.sv */
`timescale 1ns/1ps

module wb_status_regs
    import game_pkg::*, bus_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack,
    input  turn_state_e         turn,
    input  logic                game_over,
    input  player_e             winner,
    input  card_t               card_p1,
    input  card_t               card_p2,
    input  score_t              score_p1,
    input  score_t              score_p2,
    output logic                new_game
);

    reg_addr_e           addr;
    logic                req;
    logic [WB_DAT_W-1:0] rd_mux;

    assign addr = reg_addr_e'(wb_adr);
    assign req  = wb_cyc && wb_stb && !wb_ack;  // new access, ack still low

    always_comb begin
        case (addr)
            REG_STATUS:   rd_mux = {5'b0, winner, game_over, turn};
            REG_CARD_P1:  rd_mux = {3'b0, card_p1};
            REG_CARD_P2:  rd_mux = {3'b0, card_p2};
            REG_SCORE_P1: rd_mux = score_p1;
            REG_SCORE_P2: rd_mux = score_p2;
            default:      rd_mux = '0;  // control reads as zero
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_ack   <= 1'b0;
            new_game <= 1'b0;
        end else begin
            wb_ack   <= req;
            new_game <= req && wb_we && addr == REG_CONTROL && wb_dat_w[0];
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_mux;  // held valid while ack is high
        end
    end

endmodule

/* design/card_game_top.sv */
`timescale 1ns/1ps

module card_game_top
    import game_pkg::*, bus_pkg::*;
#(
    parameter int unsigned WIN_SCORE = 5,
    parameter logic [4:0]  LFSR_SEED = 5'b11100
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [3:0]          keypad,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack
);

    logic        deal;
    player_e     deal_player;
    logic        ring;
    player_e     ring_player;
    turn_state_e turn;
    logic        match;
    logic        collect;
    logic        game_over;
    player_e     winner;
    logic        new_game;
    card_t       card_p1;
    card_t       card_p2;
    score_t      score_p1;
    score_t      score_p2;

    card_if deal_bus ();  // dealer to table

    turn_control u_turn (
        .clk, .rst, .keypad, .game_over, .new_game,
        .deal, .deal_player, .ring, .ring_player, .turn
    );

    card_dealer #(.LFSR_SEED(LFSR_SEED)) u_dealer (
        .clk, .rst, .deal, .deal_player,
        .cards (deal_bus.dealer)
    );

    card_table u_table (
        .clk, .rst,
        .cards (deal_bus.tbl),
        .collect, .new_game, .card_p1, .card_p2, .match
    );

    bell_judge #(.WIN_SCORE(WIN_SCORE)) u_judge (
        .clk, .rst, .ring, .ring_player, .match, .new_game,
        .score_p1, .score_p2, .collect, .game_over, .winner
    );

    wb_status_regs u_regs (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack, .turn, .game_over, .winner,
        .card_p1, .card_p2, .score_p1, .score_p2, .new_game
    );

endmodule

/* verification/card_game_assertions.sv */
`timescale 1ns/1ps

module card_game_assertions
    import game_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_ack,
    input logic        deal_valid,
    input logic [3:0]  keypad,
    input logic        game_over,
    input logic        new_game,
    input turn_state_e turn
);

    int unsigned fails = 0;  // failed assertion count

    ack_with_request: assert property (@(posedge clk) disable iff (!rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("wb_ack high without cyc and stb");
            fails++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack held for two cycles");
            fails++;
        end

    valid_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        deal_valid |=> !deal_valid)
        else begin
            $error("card valid held for two cycles");
            fails++;
        end

    // turn moves only after the flip code of the player on turn or a new game
    turn_after_flip: assert property (@(posedge clk) disable iff (!rst)
        !$stable(turn) |-> ($past(new_game) ||
            ($past(game_over) == 1'b0 &&
             $past(keypad) == (($past(turn) == TURN_P1) ? KEY_FLIP_P1 : KEY_FLIP_P2))))
        else begin
            $error("turn changed without a flip code from the player on turn");
            fails++;
        end

endmodule

bind card_game_top card_game_assertions u_asrt (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_ack,
    .deal_valid (deal_bus.valid),
    .keypad, .game_over, .new_game, .turn
);

/* verification/card_game_tb.sv */
`timescale 1ns/1ps

module card_game_tb
    import game_pkg::*, bus_pkg::*;
();

    localparam int unsigned WIN_SCORE = 5;
    localparam logic [4:0]  LFSR_SEED = 5'b11100;
    localparam int MAX_RANDOM_KEYS = 200;
    localparam int KEY_BUDGET = 3 + 41 + 11 + MAX_RANDOM_KEYS + 4 + 1;
    localparam int BUS_BUDGET = 11 * 5 + 1;  // eleven full register sweeps, one write
    localparam int TIMEOUT_CYCLES = 20 * (KEY_BUDGET + BUS_BUDGET) + 500;

    logic                clk;
    logic                rst;
    logic [3:0]          keypad;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [WB_DAT_W-1:0] wb_dat_w;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic                wb_ack;

    // reference model state
    turn_state_e m_turn;
    logic [4:0]  m_lfsr;
    card_t       m_p1;
    card_t       m_p2;
    score_t      m_s1;
    score_t      m_s2;
    logic        m_over;
    player_e     m_winner;

    logic [15:0] rnd_state;
    int          errors = 0;
    int          other_errors = 0;
    int          cycles = 0;

    card_game_top #(.WIN_SCORE(WIN_SCORE), .LFSR_SEED(LFSR_SEED)) dut (
        .clk, .rst, .keypad, .wb_cyc, .wb_stb, .wb_we,
        .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // 16-bit galois shift, taps 16 14 13 11
    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | rnd_state[0];
            rnd_state = galois_step(rnd_state);
        end
        return v;
    endfunction

    // map the current value, then shift left with bits 4 and 2 fed back
    function automatic card_t next_card();
        card_t c;
        c.color  = 2'(m_lfsr[4:3] % 3 + 1);
        c.number = 3'(m_lfsr[2:0] % 5 + 1);
        m_lfsr   = {m_lfsr[3:0], m_lfsr[2] ^ m_lfsr[4]};
        return c;
    endfunction

    function automatic logic model_match();
        int sum;
        for (int c = 1; c <= 3; c++) begin
            sum = 0;
            if (m_p1.color == c)
                sum += m_p1.number;
            if (m_p2.color == c)
                sum += m_p2.number;
            if (sum == 5)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic model_key(input key_code_e k);
        player_e who;
        player_e paid;
        logic    hit;
        if (m_over)
            return;  // keys are dead until a new game
        if ((k == KEY_FLIP_P1 && m_turn == TURN_P1) || (k == KEY_FLIP_P2 && m_turn == TURN_P2)) begin
            if (m_turn == TURN_P1)
                m_p1 = next_card();
            else
                m_p2 = next_card();
            m_turn = (m_turn == TURN_P1) ? TURN_P2 : TURN_P1;
        end else if (k == KEY_RING_P1 || k == KEY_RING_P2) begin
            who  = (k == KEY_RING_P1) ? PLAYER1 : PLAYER2;
            hit  = model_match();
            paid = hit ? who : ((who == PLAYER1) ? PLAYER2 : PLAYER1);
            if (paid == PLAYER1)
                m_s1++;
            else
                m_s2++;
            if (hit) begin
                m_p1 = '0;
                m_p2 = '0;
            end
            if (m_s1 >= WIN_SCORE || m_s2 >= WIN_SCORE) begin
                m_over   = 1'b1;
                m_winner = paid;
            end
        end
    endtask

    // one-cycle press, then idle long enough for the table to settle
    task automatic press_key(input key_code_e k);
        @(negedge clk);
        keypad = k;
        @(negedge clk);
        keypad = KEY_NONE;
        repeat (4) @(negedge clk);
        model_key(k);
    endtask

    task automatic wb_access(input logic we, input reg_addr_e adr, input logic [7:0] wdat,
                             output logic [7:0] rdat);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        @(negedge clk);
        while (!wb_ack)
            @(negedge clk);
        rdat = wb_dat_r;
        @(negedge clk);  // ack edge is past, release the bus
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input reg_addr_e adr, output logic [7:0] rdat);
        wb_access(1'b0, adr, 8'h00, rdat);
    endtask

    task automatic wb_write(input reg_addr_e adr, input logic [7:0] wdat);
        logic [7:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic check_card(input string name, input card_t exp, input card_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected colour %0d number %0d, got colour %0d number %0d",
                     name, exp.color, exp.number, act.color, act.number);
        end
    endtask

    task automatic check_score(input string name, input score_t exp, input score_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %0d, got %0d", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected status %02h, got %02h", name, exp, act);
        end
    endtask

    // every host register against the model
    task automatic check_all(input string name);
        logic [7:0] d;
        wb_read(REG_STATUS, d);
        check_status({name, " status"}, {5'b0, m_winner, m_over, m_turn}, d);
        wb_read(REG_CARD_P1, d);
        check_card({name, " p1 card"}, m_p1, card_t'(d[4:0]));
        wb_read(REG_CARD_P2, d);
        check_card({name, " p2 card"}, m_p2, card_t'(d[4:0]));
        wb_read(REG_SCORE_P1, d);
        check_score({name, " p1 score"}, m_s1, score_t'(d));
        wb_read(REG_SCORE_P2, d);
        check_score({name, " p2 score"}, m_s2, score_t'(d));
    endtask

    task automatic test_turn_order();
        press_key(KEY_FLIP_P2);  // out of turn
        check_all("turn order, early p2 flip");
        press_key(KEY_FLIP_P1);
        check_all("turn order, p1 flip");
        press_key(KEY_FLIP_P2);
        check_all("turn order, p2 flip");
    endtask

    task automatic test_correct_ring();
        int n;
        n = 0;
        while (!model_match() && n < 40) begin
            press_key(m_turn == TURN_P1 ? KEY_FLIP_P1 : KEY_FLIP_P2);
            n++;
        end
        if (!model_match()) begin
            other_errors++;
            $display("correct ring: no colour reached five within 40 flips");
        end else begin
            press_key(KEY_RING_P1);
            check_all("correct ring");
        end
    endtask

    task automatic test_wrong_ring();
        int n;
        n = 0;
        do begin
            press_key(m_turn == TURN_P1 ? KEY_FLIP_P1 : KEY_FLIP_P2);
            n++;
        end while (model_match() && n < 10);
        if (model_match()) begin
            other_errors++;
            $display("wrong ring: could not reach a table without a match");
        end else begin
            check_all("wrong ring, before");
            press_key(KEY_RING_P2);
            check_all("wrong ring, after");
        end
    endtask

    task automatic test_random_play();
        int n;
        n = 0;
        while (!m_over && n < MAX_RANDOM_KEYS) begin
            case (take_bits(2))
                0:       press_key(KEY_FLIP_P1);
                1:       press_key(KEY_FLIP_P2);
                2:       press_key(KEY_RING_P1);
                default: press_key(KEY_RING_P2);
            endcase
            n++;
        end
        if (!m_over) begin
            other_errors++;
            $display("random play: no score reached %0d in %0d keys", WIN_SCORE, n);
        end
        check_all("random play, game over");
        press_key(KEY_FLIP_P1);
        press_key(KEY_FLIP_P2);
        press_key(KEY_RING_P1);
        press_key(KEY_RING_P2);
        check_all("random play, keys after end");
    endtask

    task automatic test_new_game();
        wb_write(REG_CONTROL, 8'h01);
        m_s1     = '0;
        m_s2     = '0;
        m_p1     = '0;
        m_p2     = '0;
        m_over   = 1'b0;
        m_winner = PLAYER1;
        m_turn   = TURN_P1;  // dealer keeps its place
        check_all("new game");
        press_key(KEY_FLIP_P1);
        check_all("new game, first deal");
    endtask

    initial begin
        rst       = 1'b0;
        keypad    = KEY_NONE;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        rnd_state = 16'd36372;
        m_turn    = TURN_P1;
        m_lfsr    = LFSR_SEED;
        m_p1      = '0;
        m_p2      = '0;
        m_s1      = '0;
        m_s2      = '0;
        m_over    = 1'b0;
        m_winner  = PLAYER1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        check_all("reset");
        test_turn_order();
        test_correct_ring();
        test_wrong_ring();
        test_random_play();
        test_new_game();

        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 errors, other_errors, dut.u_asrt.fails);
        if (errors == 0 && other_errors == 0 && dut.u_asrt.fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
design/game_pkg.sv
design/bus_pkg.sv
design/card_if.sv
design/turn_control.sv
design/card_dealer.sv
design/card_table.sv
design/bell_judge.sv
design/wb_status_regs.sv
design/card_game_top.sv
verification/card_game_assertions.sv
verification/card_game_tb.sv
